/* wh_mem_pkg.sv */
`default_nettype none

package wh_mem_pkg;

  // link and block geometry
  localparam int flit_width_lp = 32;
  localparam int data_len_lp = 4;
  localparam int block_width_lp = flit_width_lp * data_len_lp;
  localparam int block_offset_width_lp = 4;

  // block memory size
  localparam int mem_els_lp = 64;
  localparam int mem_addr_width_lp = $clog2(mem_els_lp);

  // header field widths
  localparam int cord_width_lp = 8;
  localparam int cid_width_lp = 2;
  localparam int len_width_lp = 4;

  // one direction of a ready_and link
  typedef struct packed {
    logic v;
    logic ready_and_rev;
    logic [flit_width_lp-1:0] data;
  } wh_link_s;

  // header flit, dest_cord in the low bits
  typedef struct packed {
    logic [flit_width_lp-2-(2*cord_width_lp)-cid_width_lp-len_width_lp:0] unused;
    logic write_not_read;
    logic [cord_width_lp-1:0] src_cord;
    logic [cid_width_lp-1:0] cid;
    logic [len_width_lp-1:0] len;
    logic [cord_width_lp-1:0] dest_cord;
  } wh_header_s;

  // a link word is either a header or a data/address flit
  typedef union packed {
    wh_header_s header;
    logic [flit_width_lp-1:0] data;
  } wh_flit_u;

  // memory request from an endpoint, held until granted
  typedef struct packed {
    logic v;
    logic w;
    logic [mem_addr_width_lp-1:0] addr;
    logic [block_width_lp-1:0] data;
  } mem_req_s;

endpackage

`default_nettype wire

/* block_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module block_mem
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  mem_req_s req_i,
    output logic [block_width_lp-1:0] rdata_o
  );

  logic [block_width_lp-1:0] mem_r [mem_els_lp];

  always_ff @(posedge clk_i) begin
    if (req_i.v) begin
      if (req_i.w) begin
        mem_r[req_i.addr] <= req_i.data;
      end else begin
        // read data shows up the cycle after the grant
        rdata_o <= mem_r[req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* block_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module block_mem_arbiter
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  logic reset_i,
    input  mem_req_s req0_i,
    input  mem_req_s req1_i,
    output logic gnt0_o,
    output logic gnt1_o,
    output mem_req_s mem_req_o
  );

  // high when endpoint 0 won the last grant
  logic last0_r;

  // on a tie the endpoint not granted last time wins
  assign gnt0_o = req0_i.v & (~req1_i.v | ~last0_r);
  assign gnt1_o = req1_i.v & ~gnt0_o;

  always_comb begin
    mem_req_o = gnt1_o ? req1_i : req0_i;
    mem_req_o.v = gnt0_o | gnt1_o;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last0_r <= 1'b0;
    end else if (gnt0_o | gnt1_o) begin
      last0_r <= gnt0_o;
    end
  end

endmodule

`default_nettype wire

/* flit_sipo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_sipo
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  logic reset_i,
    input  logic v_i,
    input  logic [flit_width_lp-1:0] data_i,
    output logic [block_width_lp-1:0] block_o
  );

  logic [block_width_lp-1:0] block_r;

  // new flits enter at the top, so the first one ends up lowest
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      block_r <= '0;
    end else if (v_i) begin
      block_r <= {data_i, block_r[block_width_lp-1:flit_width_lp]};
    end
  end

  assign block_o = block_r;

endmodule

`default_nettype wire

/* flit_piso.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_piso
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  logic reset_i,
    input  logic load_i,
    input  logic [block_width_lp-1:0] block_i,
    input  logic yumi_i,
    output logic [flit_width_lp-1:0] data_o
  );

  logic [block_width_lp-1:0] block_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      block_r <= '0;
    end else if (load_i) begin
      block_r <= block_i;
    end else if (yumi_i) begin
      // next flit moves into the low slot
      block_r <= {{flit_width_lp{1'b0}}, block_r[block_width_lp-1:flit_width_lp]};
    end
  end

  assign data_o = block_r[flit_width_lp-1:0];

endmodule

`default_nettype wire

/* wh_mem_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_mem_endpoint
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  logic reset_i,
    input  wh_link_s link_i,
    output wh_link_s link_o,
    output mem_req_s mem_req_o,
    input  logic mem_gnt_i,
    input  logic [block_width_lp-1:0] mem_rdata_i
  );

  typedef enum logic [2:0] {
    RESET,
    READY,
    RECV_ADDR,
    RECV_EVICT_DATA,
    WAIT_WRITE_GNT,
    WAIT_READ_GNT,
    SEND_FILL_HEADER,
    SEND_FILL_DATA
  } ep_state_e;

  ep_state_e state_r, state_n;

  logic write_not_read_r, write_not_read_n;
  logic [cord_width_lp-1:0] src_cord_r, src_cord_n;
  logic [cid_width_lp-1:0] cid_r, cid_n;
  logic [flit_width_lp-1:0] addr_r, addr_n;
  logic [1:0] cnt_r, cnt_n;
  logic loaded_r;

  wh_flit_u flit_in;
  wh_flit_u flit_out;
  logic cnt_last;
  logic sipo_v;
  logic piso_load;
  logic piso_yumi;
  logic [flit_width_lp-1:0] piso_data;
  logic [block_width_lp-1:0] wdata_block;
  logic [mem_addr_width_lp-1:0] blk_addr;

  assign flit_in = link_i.data;
  assign cnt_last = (cnt_r == 2'(data_len_lp-1));

  // fill reply header goes back to the requester
  assign flit_out.header = '{
    unused: '0,
    write_not_read: 1'b0,
    src_cord: '0,
    cid: cid_r,
    len: len_width_lp'(data_len_lp),
    dest_cord: src_cord_r
  };

  // src_cord bit 0 picks the half, address picks the block
  assign blk_addr = {src_cord_r[0], addr_r[block_offset_width_lp +: mem_addr_width_lp-1]};

  // rdata is only valid on the first header cycle
  assign piso_load = (state_r == SEND_FILL_HEADER) & ~loaded_r;

  flit_sipo sipo_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(sipo_v),
    .data_i(flit_in.data),
    .block_o(wdata_block)
  );

  flit_piso piso_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .load_i(piso_load),
    .block_i(mem_rdata_i),
    .yumi_i(piso_yumi),
    .data_o(piso_data)
  );

  always_comb begin
    state_n = state_r;
    write_not_read_n = write_not_read_r;
    src_cord_n = src_cord_r;
    cid_n = cid_r;
    addr_n = addr_r;
    cnt_n = cnt_r;
    link_o = '0;
    sipo_v = 1'b0;
    piso_yumi = 1'b0;

    case (state_r)
      RESET: begin
        state_n = READY;
      end
      READY: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          write_not_read_n = flit_in.header.write_not_read;
          src_cord_n = flit_in.header.src_cord;
          cid_n = flit_in.header.cid;
          state_n = RECV_ADDR;
        end
      end
      RECV_ADDR: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          addr_n = flit_in.data;
          state_n = write_not_read_r ? RECV_EVICT_DATA : WAIT_READ_GNT;
        end
      end
      RECV_EVICT_DATA: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          sipo_v = 1'b1;
          cnt_n = cnt_r + 2'd1;
          if (cnt_last) begin
            state_n = WAIT_WRITE_GNT;
          end
        end
      end
      WAIT_WRITE_GNT: begin
        if (mem_gnt_i) begin
          state_n = READY;
        end
      end
      WAIT_READ_GNT: begin
        if (mem_gnt_i) begin
          state_n = SEND_FILL_HEADER;
        end
      end
      SEND_FILL_HEADER: begin
        link_o.v = 1'b1;
        link_o.data = flit_out.data;
        if (link_i.ready_and_rev) begin
          state_n = SEND_FILL_DATA;
        end
      end
      SEND_FILL_DATA: begin
        link_o.v = 1'b1;
        link_o.data = piso_data;
        if (link_i.ready_and_rev) begin
          piso_yumi = 1'b1;
          cnt_n = cnt_r + 2'd1;
          if (cnt_last) begin
            state_n = READY;
          end
        end
      end
      default: begin
        state_n = READY;
      end
    endcase
  end

  always_comb begin
    mem_req_o.v = (state_r == WAIT_WRITE_GNT) | (state_r == WAIT_READ_GNT);
    mem_req_o.w = (state_r == WAIT_WRITE_GNT);
    mem_req_o.addr = blk_addr;
    mem_req_o.data = wdata_block;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      cnt_r <= '0;
      loaded_r <= 1'b0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      loaded_r <= (state_r == SEND_FILL_HEADER);
    end
  end

  // request fields
  always_ff @(posedge clk_i) begin
    write_not_read_r <= write_not_read_n;
    src_cord_r <= src_cord_n;
    cid_r <= cid_n;
    addr_r <= addr_n;
  end

endmodule

`default_nettype wire

/* wh_dual_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_dual_mem
  import wh_mem_pkg::*;
  (
    input  logic clk_i,
    input  logic reset_i,
    input  wh_link_s link0_i,
    input  wh_link_s link1_i,
    output wh_link_s link0_o,
    output wh_link_s link1_o
  );

  mem_req_s req0, req1, mem_req;
  logic gnt0, gnt1;
  logic [block_width_lp-1:0] mem_rdata;

  wh_mem_endpoint ep0_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .link_i(link0_i),
    .link_o(link0_o),
    .mem_req_o(req0),
    .mem_gnt_i(gnt0),
    .mem_rdata_i(mem_rdata)
  );

  wh_mem_endpoint ep1_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .link_i(link1_i),
    .link_o(link1_o),
    .mem_req_o(req1),
    .mem_gnt_i(gnt1),
    .mem_rdata_i(mem_rdata)
  );

  block_mem_arbiter arb_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req0_i(req0),
    .req1_i(req1),
    .gnt0_o(gnt0),
    .gnt1_o(gnt1),
    .mem_req_o(mem_req)
  );

  // shared by both links
  block_mem mem_i (
    .clk_i(clk_i),
    .req_i(mem_req),
    .rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // 100 ns period
  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* wh_dual_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_dual_mem_tb
  import wh_mem_pkg::*;
  ();

  localparam int timeout_cycles_lp = 3000;

  logic clk;
  logic reset;
  logic in_v [2];
  logic in_ready [2];
  logic [31:0] in_data [2];
  wh_link_s link0_in, link1_in, link0_out, link1_out;
  logic [127:0] model [64];
  logic [31:0] exp0_q [$];
  logic [31:0] exp1_q [$];
  logic [31:0] lfsr = 32'hb62d97d0;
  logic rand_ready = 1'b0;
  int fail_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycles;

  tb_clock_gen clk_gen_i (.clk_o(clk));

  assign link0_in = '{v: in_v[0], ready_and_rev: in_ready[0], data: in_data[0]};
  assign link1_in = '{v: in_v[1], ready_and_rev: in_ready[1], data: in_data[1]};

  wh_dual_mem dut_i (
    .clk_i(clk),
    .reset_i(reset),
    .link0_i(link0_in),
    .link1_i(link1_in),
    .link0_o(link0_out),
    .link1_o(link1_out)
  );

  // taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // reply header sent back to the requester with len 4
  function automatic logic [31:0] fill_header(input logic [7:0] src, input logic [1:0] cid);
    return {9'b0, 1'b0, 8'h00, cid, 4'd4, src};
  endfunction

  function automatic logic [5:0] blk_index(input logic [7:0] src, input logic [31:0] addr);
    return {src[0], addr[8:4]};
  endfunction

  function automatic logic link_ready(input int l);
    return (l == 0) ? link0_out.ready_and_rev : link1_out.ready_and_rev;
  endfunction

  function automatic int exp_size(input int l);
    return (l == 0) ? exp0_q.size() : exp1_q.size();
  endfunction

  function automatic logic [31:0] pop_exp(input int l);
    return (l == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
  endfunction

  task automatic push_exp(input int l, input logic [31:0] d);
    if (l == 0) begin
      exp0_q.push_back(d);
    end else begin
      exp1_q.push_back(d);
    end
  endtask

  task automatic send_flit(input int l, input logic [31:0] d);
    in_v[l] = 1'b1;
    in_data[l] = d;
    while (!link_ready(l)) @(negedge clk);
    @(negedge clk);
    in_v[l] = 1'b0;
  endtask

  task automatic evict(input int l, input logic [7:0] src, input logic [31:0] addr);
    logic [127:0] blk;
    blk = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    model[blk_index(src, addr)] = blk;
    send_flit(l, {9'b0, 1'b1, src, 2'(rand_bits(2)), 4'd4, 8'h00});
    send_flit(l, addr);
    for (int i = 0; i < 4; i++) begin
      send_flit(l, blk[32*i +: 32]);
    end
    // ready comes back once the write is granted
    while (!link_ready(l)) @(negedge clk);
  endtask

  task automatic fill(input int l, input logic [7:0] src, input logic [31:0] addr);
    logic [1:0] cid;
    logic [127:0] blk;
    cid = 2'(rand_bits(2));
    blk = model[blk_index(src, addr)];
    push_exp(l, fill_header(src, cid));
    for (int i = 0; i < 4; i++) begin
      push_exp(l, blk[32*i +: 32]);
    end
    send_flit(l, {9'b0, 1'b0, src, cid, 4'd0, 8'h00});
    send_flit(l, addr);
    while (exp_size(l) != 0) @(negedge clk);
  endtask

  task automatic check_out(input int l, input wh_link_s out, input logic ready);
    logic [31:0] want;
    if (out.v) begin
      assert (exp_size(l) != 0) else begin
        $display("link%0d_o sent a flit with no fill outstanding", l);
        fail_count++;
      end
    end
    if (out.v && ready && exp_size(l) != 0) begin
      want = pop_exp(l);
      assert (out.data == want) else begin
        $display("MISMATCH link%0d_o.data expected %h observed %h", l, want, out.data);
        fail_count++;
      end
    end
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    if (fail_count == errs_before) begin
      tests_passed++;
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", num, name, fail_count - errs_before);
    end
  endtask

  // receiving side ready pattern and output flit checks
  initial begin
    in_ready[0] = 1'b0;
    in_ready[1] = 1'b0;
    forever begin
      @(negedge clk);
      in_ready[0] = rand_ready ? lfsr_step() : 1'b1;
      in_ready[1] = rand_ready ? lfsr_step() : 1'b1;
      if (!reset) begin
        check_out(0, link0_out, in_ready[0]);
        check_out(1, link1_out, in_ready[1]);
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
      (link0_out.v && !in_ready[0]) |=> (link0_out.v && $stable(link0_out.data)))
    else begin
      $display("link0_o dropped or changed a flit before it was accepted");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
      (link1_out.v && !in_ready[1]) |=> (link1_out.v && $stable(link1_out.data)))
    else begin
      $display("link1_o dropped or changed a flit before it was accepted");
      fail_count++;
    end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles_lp) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Something failed");
    $finish;
  end

  initial begin
    int errs;
    logic [7:0] src;
    logic [31:0] addr;
    reset = 1'b1;
    in_v[0] = 1'b0;
    in_v[1] = 1'b0;
    in_data[0] = '0;
    in_data[1] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errs = fail_count;
    repeat (3) begin
      assert (!link0_out.v && !link1_out.v) else begin
        $display("link output valid right after reset");
        fail_count++;
      end
      @(negedge clk);
    end
    while (!(link_ready(0) && link_ready(1))) @(negedge clk);
    end_test(1, "reset", errs);

    errs = fail_count;
    src = 8'(rand_bits(8));
    addr = rand_bits(32);
    evict(0, src, addr);
    fill(0, src, addr);
    end_test(2, "evict then fill on link 0", errs);

    errs = fail_count;
    src = 8'(rand_bits(8));
    addr = rand_bits(32);
    evict(0, src ^ 8'h01, addr);
    evict(1, src, addr);
    // only bit 0 of src and bits 8:4 of addr select the block
    fill(0, src ^ 8'hf0, addr ^ 32'hfffffe0f);
    fill(0, src ^ 8'h01, addr);
    end_test(3, "shared memory and hashing", errs);

    errs = fail_count;
    fork
      fill(0, src, addr);
      evict(1, src, addr + 32'h10);
    join
    fork
      fill(1, src, addr + 32'h10);
      fill(0, src ^ 8'h01, addr);
    join
    fork
      evict(0, src, addr);
      evict(1, src ^ 8'h01, addr + 32'h10);
    join
    fork
      fill(0, src ^ 8'h01, addr + 32'h10);
      fill(1, src, addr);
    join
    end_test(4, "both links at once", errs);

    errs = fail_count;
    rand_ready = 1'b1;
    repeat (3) begin
      fork
        fill(0, src, addr);
        fill(1, src ^ 8'h01, addr + 32'h10);
      join
    end
    evict(1, src, addr + 32'h40);
    fill(0, src, addr + 32'h40);
    rand_ready = 1'b0;
    end_test(5, "random back-pressure", errs);

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
wh_mem_pkg.sv
block_mem.sv
block_mem_arbiter.sv
flit_sipo.sv
flit_piso.sv
wh_mem_endpoint.sv
wh_dual_mem.sv
tb_clock_gen.sv
wh_dual_mem_tb.sv
